// File: Bender.yml
package:
  name: periph

sources:
  - include_dirs:
      - logic
    files:
      - logic/periph_pkg.sv
      - logic/apb_splitter.sv
      - logic/pwm_channel.sv
      - logic/gpio_pads.sv
      - logic/periph_top.sv
  - target: test
    include_dirs:
      - logic
      - bench
    files:
      - bench/tb_periph.sv

// File: bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==================================================
//  APB master
// ==================================================

// Setup phase, access phase until pready, then back to idle
task automatic apb_access(input paddr_t addr, input logic wr, input word_t wdata,
		output apb_rsp_t rsp);
	@(negedge clk_sys);
	apb_req.paddr   = addr;
	apb_req.psel    = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite  = wr;
	apb_req.pwdata  = wdata;
	@(negedge clk_sys);
	apb_req.penable = 1'b1;
	#(SAMPLE_DLY);
	while (!apb_rsp.pready) begin // A stuck slave runs into the cycle limit
		@(negedge clk_sys);
		#(SAMPLE_DLY);
	end
	rsp = apb_rsp;
	@(posedge clk_sys); // Transfer completes here
	@(negedge clk_sys);
	apb_req = '0;
endtask

task automatic bus_write(input int slot, input offs_t offs, input word_t data);
	apb_rsp_t rsp;
	apb_access(make_addr(slot, offs), 1'b1, data, rsp);
	check_rsp(rsp, slot >= `PERIPH_N_SLOTS,
		$sformatf("write slot %0d offset %h", slot, offs));
	model_write(slot, offs, data);
endtask

task automatic bus_read(input int slot, input offs_t offs, output word_t data);
	apb_rsp_t rsp;
	apb_access(make_addr(slot, offs), 1'b0, '0, rsp);
	check_rsp(rsp, slot >= `PERIPH_N_SLOTS,
		$sformatf("read slot %0d offset %h", slot, offs));
	data = rsp.prdata;
endtask

// ==================================================
//  Compare tasks
// ==================================================

task automatic check_word(input word_t got, input word_t exp, input string what);
	if (got !== exp) begin
		$display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
		report_failure();
	end
endtask

task automatic check_pads(input pad_vec_t got, input pad_vec_t exp, input string what);
	if (got !== exp) begin
		$display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		report_failure();
	end
endtask

task automatic check_rsp(input apb_rsp_t rsp, input logic exp_err, input string what);
	if (rsp.pslverr !== exp_err) begin
		$display("Fail at %0t ns: %s pslverr %b, expected %b", $time, what,
			rsp.pslverr, exp_err);
		report_failure();
	end
endtask

`endif

// File: bench/tb_periph.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_config.svh"

module tb_periph;

import periph_pkg::*;

localparam int SAMPLE_DLY     = 1; // Sample point inside the low clock phase
localparam int RESET_CYCLES   = 10;
localparam int N_READBACK     = 200;
localparam int N_GPIO         = 32;
localparam int DISABLE_CYCLES = 64;
localparam int N_SLOT_CODES   = 1 << (`PERIPH_W_PADDR - `PERIPH_W_OFFS);

// Rough length of every test, in clock cycles
localparam int ACCESS_CYCLES  = 3;
localparam int SWEEP_ACCESSES = 4 + 4 * `PERIPH_N_PWM;
localparam int TEST_CYCLES    = 2 * RESET_CYCLES
	+ 3 * SWEEP_ACCESSES * ACCESS_CYCLES
	+ N_READBACK * 2 * ACCESS_CYCLES
	+ (N_SLOT_CODES - `PERIPH_N_SLOTS) * 2 * ACCESS_CYCLES
	+ N_GPIO * (3 * ACCESS_CYCLES + 4)
	+ `PERIPH_N_PWM * (5 * ACCESS_CYCLES + 256 * 4 + DISABLE_CYCLES);
localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

logic     clk_sys;
logic     rst_n;
apb_req_t apb_req;
apb_rsp_t apb_rsp;
pad_vec_t padout;
pad_vec_t padoe;
pad_vec_t padin;

integer seed = 32'h3c1c;
int     cycle_count = 0;

// Register model
logic     pwm_en  [`PERIPH_N_PWM];
duty_t    pwm_div [`PERIPH_N_PWM];
duty_t    pwm_cmp [`PERIPH_N_PWM];
pad_vec_t gpio_out;
pad_vec_t gpio_oe;
pad_vec_t gpio_fsel;

// Offset 0x00C is unused in a PWM channel and reads zero
offs_t pwm_offs  [4] = '{`PWM_REG_CSR, `PWM_REG_DIV, `PWM_REG_CMP, 12'h00C};
offs_t gpio_offs [4] = '{`GPIO_REG_OUT, `GPIO_REG_OE, `GPIO_REG_IN, `GPIO_REG_FSEL};

periph_top u_periph_top (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.apb_req (apb_req),
	.apb_rsp (apb_rsp),
	.padout  (padout),
	.padoe   (padoe),
	.padin   (padin)
);

initial begin
	clk_sys = 1'b0;
	forever #2 clk_sys = ~clk_sys;
end

always @(posedge clk_sys) begin
	cycle_count <= cycle_count + 1;
	if (cycle_count >= TIMEOUT_CYCLES) begin
		$display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
		report_failure();
	end
end

task automatic report_failure();
	$display("Test failed");
	$fatal(1, "Simulation stopped at the first error");
endtask

// ==================================================
//  Model
// ==================================================

function automatic paddr_t make_addr(input int slot, input offs_t offs);
	return {slot_t'(slot), offs};
endfunction

function automatic void model_reset();
	for (int k = 0; k < `PERIPH_N_PWM; k++) begin
		pwm_en[k]  = 1'b0;
		pwm_div[k] = '0;
		pwm_cmp[k] = '0;
	end
	gpio_out  = '0;
	gpio_oe   = '0;
	gpio_fsel = '0;
endfunction

function automatic void model_write(input int slot, input offs_t offs, input word_t data);
	if (slot == `PERIPH_SLOT_GPIO) begin
		case (offs)
			`GPIO_REG_OUT:  gpio_out  = data[`PERIPH_N_PADS-1:0];
			`GPIO_REG_OE:   gpio_oe   = data[`PERIPH_N_PADS-1:0];
			`GPIO_REG_FSEL: gpio_fsel = data[`PERIPH_N_PADS-1:0];
			default: ;
		endcase
	end else if (slot <= `PERIPH_N_PWM) begin
		case (offs)
			`PWM_REG_CSR: pwm_en[slot-1]  = data[0];
			`PWM_REG_DIV: pwm_div[slot-1] = data[7:0];
			`PWM_REG_CMP: pwm_cmp[slot-1] = data[7:0];
			default: ;
		endcase
	end
endfunction

function automatic word_t expected_read(input int slot, input offs_t offs);
	if (slot == `PERIPH_SLOT_GPIO) begin
		case (offs)
			`GPIO_REG_OUT:  return word_t'(gpio_out);
			`GPIO_REG_OE:   return word_t'(gpio_oe);
			`GPIO_REG_IN:   return word_t'(padin); // Held long enough to pass the sync
			`GPIO_REG_FSEL: return word_t'(gpio_fsel);
			default:        return '0;
		endcase
	end else if (slot <= `PERIPH_N_PWM) begin
		case (offs)
			`PWM_REG_CSR: return word_t'(pwm_en[slot-1]);
			`PWM_REG_DIV: return word_t'(pwm_div[slot-1]);
			`PWM_REG_CMP: return word_t'(pwm_cmp[slot-1]);
			default:      return '0;
		endcase
	end
	return '0; // Unmapped slot
endfunction

`include "tb_checks.svh"

// ==================================================
//  Test steps
// ==================================================

task automatic apply_reset();
	@(negedge clk_sys);
	rst_n = 1'b0;
	padin = '0;
	model_reset();
	repeat (RESET_CYCLES) @(negedge clk_sys);
	rst_n = 1'b1;
endtask

task automatic check_all_regs(input string tag);
	word_t rd;
	for (int slot = 0; slot < `PERIPH_N_SLOTS; slot++) begin
		for (int i = 0; i < 4; i++) begin
			offs_t offs;
			offs = (slot == `PERIPH_SLOT_GPIO) ? gpio_offs[i] : pwm_offs[i];
			bus_read(slot, offs, rd);
			check_word(rd, expected_read(slot, offs),
				$sformatf("%s, slot %0d offset %h", tag, slot, offs));
		end
	end
endtask

task automatic check_reset_state(input string tag);
	check_pads(padout, '0, {tag, ", padout"});
	check_pads(padoe, '0, {tag, ", padoe"});
	check_all_regs(tag);
endtask

initial begin
	int       slot;
	int       idx;
	int       high;
	int       high_all;
	offs_t    offs;
	word_t    data;
	word_t    rd;
	word_t    exp_high;
	duty_t    div_v;
	duty_t    cmp_v;
	pad_vec_t mask;

	apb_req = '0;
	padin   = '0;
	rst_n   = 1'b0;
	apply_reset();
	check_reset_state("after power-on reset");

	// Random register writes, each read back at once
	for (int n = 0; n < N_READBACK; n++) begin
		slot = $unsigned($random(seed)) % `PERIPH_N_SLOTS;
		idx  = $unsigned($random(seed)) % 4;
		offs = (slot == `PERIPH_SLOT_GPIO) ? gpio_offs[idx] : pwm_offs[idx];
		data = word_t'($random(seed));
		bus_write(slot, offs, data);
		bus_read(slot, offs, rd);
		check_word(rd, expected_read(slot, offs),
			$sformatf("readback slot %0d offset %h", slot, offs));
	end

	// Unmapped slots answer with an error and touch nothing
	for (int s = `PERIPH_N_SLOTS; s < N_SLOT_CODES; s++) begin
		idx = $unsigned($random(seed)) % 4;
		bus_write(s, gpio_offs[idx], word_t'($random(seed)));
		bus_read(s, gpio_offs[idx], rd);
		check_word(rd, '0, $sformatf("unmapped slot %0d", s));
	end
	check_all_regs("after unmapped accesses");

	// ==================================================
	//  GPIO pads
	// ==================================================

	bus_write(`PERIPH_SLOT_GPIO, `GPIO_REG_FSEL, '0);
	for (int n = 0; n < N_GPIO; n++) begin
		bus_write(`PERIPH_SLOT_GPIO, `GPIO_REG_OUT, word_t'($random(seed)));
		bus_write(`PERIPH_SLOT_GPIO, `GPIO_REG_OE, word_t'($random(seed)));
		check_pads(padout, gpio_out, "padout after OUT write");
		check_pads(padoe, gpio_oe, "padoe after OE write");
		@(negedge clk_sys);
		padin = pad_vec_t'($random(seed));
		repeat (3) @(negedge clk_sys); // Two sync flops plus margin
		bus_read(`PERIPH_SLOT_GPIO, `GPIO_REG_IN, rd);
		check_word(rd, word_t'(padin), "IN after padin change");
	end

	// ==================================================
	//  PWM duty and disable
	// ==================================================

	for (int k = 0; k < `PERIPH_N_PWM; k++) begin
		div_v = duty_t'($unsigned($random(seed)) % 4);
		cmp_v = duty_t'($random(seed));
		mask  = '0;
		for (int i = k; i < `PERIPH_N_PADS; i += `PERIPH_N_PWM) begin
			mask[i] = 1'b1; // Every pad i with i mod N_PWM == k takes channel k
		end
		exp_high = word_t'(int'(cmp_v) * (int'(div_v) + 1));
		bus_write(k + 1, `PWM_REG_DIV, word_t'(div_v));
		bus_write(k + 1, `PWM_REG_CMP, word_t'(cmp_v));
		bus_write(`PERIPH_SLOT_GPIO, `GPIO_REG_FSEL, word_t'(mask));
		bus_write(k + 1, `PWM_REG_CSR, 32'h1);
		high     = 0;
		high_all = 0;
		repeat (256 * (int'(div_v) + 1)) begin
			@(negedge clk_sys);
			if ((padout & mask) != '0) high++;
			if ((padout & mask) == mask) high_all++;
		end
		check_pads(padoe & mask, mask, $sformatf("padoe on PWM pads of channel %0d", k));
		check_word(word_t'(high), exp_high,
			$sformatf("high cycles of channel %0d, DIV %0d CMP %0d", k, div_v, cmp_v));
		check_word(word_t'(high_all), exp_high,
			$sformatf("high cycles on all pads of channel %0d", k));

		bus_write(k + 1, `PWM_REG_CSR, '0);
		repeat (DISABLE_CYCLES) begin
			@(negedge clk_sys);
			check_pads(padout & mask, '0, $sformatf("disabled PWM pads of channel %0d", k));
		end
	end

	apply_reset();
	check_reset_state("after second reset");

	$display("Test completed successfully");
	$finish;
end

endmodule

`default_nettype wire

// File: logic/apb_splitter.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_config.svh"

module apb_splitter (
	input  logic                 clk_sys,
	input  logic                 rst_n,

	// Upstream port from the bridge
	input  periph_pkg::apb_req_t up_req,
	output periph_pkg::apb_rsp_t up_rsp,

	// One port per 4 KiB slot
	output periph_pkg::apb_req_t down_req [`PERIPH_N_SLOTS],
	input  periph_pkg::apb_rsp_t down_rsp [`PERIPH_N_SLOTS]
);

import periph_pkg::*;

slot_t                     slot;
logic [`PERIPH_N_SLOTS-1:0] down_psel;

assign slot = up_req.paddr[`PERIPH_W_PADDR-1:`PERIPH_W_OFFS];

// ==================================================
//  Request fan-out
// ==================================================

always_comb begin
	for (int i = 0; i < `PERIPH_N_SLOTS; i++) begin
		down_psel[i] = up_req.psel && (slot == slot_t'(i));

		down_req[i].paddr   = paddr_t'(up_req.paddr[`PERIPH_W_OFFS-1:0]); // Slot bits stripped
		down_req[i].psel    = down_psel[i];
		down_req[i].penable = up_req.penable && down_psel[i]; // Idle slaves see no access phase
		down_req[i].pwrite  = up_req.pwrite;
		down_req[i].pwdata  = up_req.pwdata;
	end
end

// ==================================================
//  Response merge
// ==================================================

always_comb begin
	// Unmapped slot answers here with an error and no data
	up_rsp.prdata  = '0;
	up_rsp.pready  = 1'b1;
	up_rsp.pslverr = 1'b1;
	for (int i = 0; i < `PERIPH_N_SLOTS; i++) begin
		if (slot == slot_t'(i)) begin
			up_rsp = down_rsp[i];
		end
	end
end

// ==================================================
//  Checks
// ==================================================

// Decode selects at most one slave per transfer
assert property (@(posedge clk_sys) disable iff (!rst_n)
	$onehot0(down_psel))
	else $error("apb_splitter: more than one slave selected");

endmodule

`default_nettype wire

// File: logic/gpio_pads.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_config.svh"

module gpio_pads (
	input  logic                 clk_sys,
	input  logic                 rst_n,

	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,

	// One output per PWM channel
	input  periph_pkg::pwm_vec_t pwm_in,

	output periph_pkg::pad_vec_t padout,
	output periph_pkg::pad_vec_t padoe,
	input  periph_pkg::pad_vec_t padin
);

import periph_pkg::*;

offs_t    offs;
logic     wr_en;

pad_vec_t out_reg;
pad_vec_t oe_reg;
pad_vec_t fsel;
pad_vec_t pwm_pad; // PWM channel seen by each pad

pad_vec_t in_meta; // First synchroniser stage
pad_vec_t in_sync;

assign offs  = apb_req.paddr[`PERIPH_W_OFFS-1:0];
assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;

// ==================================================
//  Registers
// ==================================================

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		out_reg <= '0;
		oe_reg  <= '0;
		fsel    <= '0;
	end else if (wr_en) begin
		case (offs)
			`GPIO_REG_OUT:  out_reg <= apb_req.pwdata[`PERIPH_N_PADS-1:0];
			`GPIO_REG_OE:   oe_reg  <= apb_req.pwdata[`PERIPH_N_PADS-1:0];
			`GPIO_REG_FSEL: fsel    <= apb_req.pwdata[`PERIPH_N_PADS-1:0];
			default: ; // IN ignores writes
		endcase
	end
end

// Two flops before padin is visible on the bus
always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		in_meta <= '0;
		in_sync <= '0;
	end else begin
		in_meta <= padin;
		in_sync <= in_meta;
	end
end

always_comb begin
	apb_rsp.pready  = 1'b1;
	apb_rsp.pslverr = 1'b0;
	case (offs)
		`GPIO_REG_OUT:  apb_rsp.prdata = word_t'(out_reg);
		`GPIO_REG_OE:   apb_rsp.prdata = word_t'(oe_reg);
		`GPIO_REG_IN:   apb_rsp.prdata = word_t'(in_sync);
		`GPIO_REG_FSEL: apb_rsp.prdata = word_t'(fsel);
		default:        apb_rsp.prdata = '0;
	endcase
end

// ==================================================
//  Pad function select
// ==================================================

// Pad i takes channel i mod N_PWM, so channels repeat across the pads
always_comb begin
	for (int i = 0; i < `PERIPH_N_PADS; i++) begin
		pwm_pad[i] = pwm_in[i % `PERIPH_N_PWM];
	end
end

assign padout = (fsel & pwm_pad) | (~fsel & out_reg);
assign padoe  = fsel | oe_reg; // PWM pads always drive

assert property (@(posedge clk_sys) disable iff (!rst_n)
	(padoe & fsel) == fsel)
	else $error("gpio_pads: PWM pad not driving");

endmodule

`default_nettype wire

// File: logic/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// ==================================================
//  Sizes
// ==================================================

`define PERIPH_N_PADS    8
`define PERIPH_N_PWM     4
`define PERIPH_W_PADDR   16
`define PERIPH_W_DATA    32
`define PERIPH_W_OFFS    12 // Offset bits inside one 4 KiB slot
`define PERIPH_W_DUTY    8  // PWM counter, compare and divisor

`define PERIPH_N_SLOTS   (1 + `PERIPH_N_PWM)
`define PERIPH_SLOT_GPIO 0  // PWM channel k decodes at slot k+1

// ==================================================
//  Register offsets
// ==================================================

`define PWM_REG_CSR  12'h000 // Bit 0 is enable
`define PWM_REG_DIV  12'h004
`define PWM_REG_CMP  12'h008

`define GPIO_REG_OUT  12'h000
`define GPIO_REG_OE   12'h004
`define GPIO_REG_IN   12'h008 // Read only
`define GPIO_REG_FSEL 12'h00C

`endif

// File: logic/periph_pkg.sv
`include "periph_config.svh"

package periph_pkg;

// ==================================================
//  Vector types
// ==================================================

typedef logic [`PERIPH_W_PADDR-1:0] paddr_t;
typedef logic [`PERIPH_W_DATA-1:0]  word_t;
typedef logic [`PERIPH_N_PADS-1:0]  pad_vec_t;
typedef logic [`PERIPH_N_PWM-1:0]   pwm_vec_t;
typedef logic [`PERIPH_W_DUTY-1:0]  duty_t;

// Address split into slot number and register offset
typedef logic [`PERIPH_W_OFFS-1:0]                 offs_t;
typedef logic [`PERIPH_W_PADDR-`PERIPH_W_OFFS-1:0] slot_t;

// ==================================================
//  APB3 channels
// ==================================================

// Master to slave, 51 bits
typedef struct packed {
	paddr_t paddr;
	logic   psel;
	logic   penable;
	logic   pwrite;
	word_t  pwdata;
} apb_req_t;

// Slave to master, 34 bits
typedef struct packed {
	word_t prdata;
	logic  pready;
	logic  pslverr;
} apb_rsp_t;

endpackage

// File: logic/periph_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_config.svh"

module periph_top (
	input  logic                 clk_sys,
	input  logic                 rst_n,

	// APB slave port from the AHB-to-APB bridge
	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,

	output periph_pkg::pad_vec_t padout,
	output periph_pkg::pad_vec_t padoe,
	input  periph_pkg::pad_vec_t padin
);

import periph_pkg::*;

// ==================================================
//  Interconnect
// ==================================================

apb_req_t slot_req [`PERIPH_N_SLOTS];
apb_rsp_t slot_rsp [`PERIPH_N_SLOTS];
pwm_vec_t pwm_out;

apb_splitter u_apb_splitter (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.up_req   (apb_req),
	.up_rsp   (apb_rsp),
	.down_req (slot_req),
	.down_rsp (slot_rsp)
);

// ==================================================
//  Slaves
// ==================================================

gpio_pads u_gpio_pads (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.apb_req (slot_req[`PERIPH_SLOT_GPIO]),
	.apb_rsp (slot_rsp[`PERIPH_SLOT_GPIO]),
	.pwm_in  (pwm_out),
	.padout  (padout),
	.padoe   (padoe),
	.padin   (padin)
);

// Channel k in slot k+1
generate
	for (genvar k = 0; k < `PERIPH_N_PWM; k++) begin : g_pwm
		pwm_channel u_pwm_channel (
			.clk_sys (clk_sys),
			.rst_n   (rst_n),
			.apb_req (slot_req[k + 1]),
			.apb_rsp (slot_rsp[k + 1]),
			.pwm_out (pwm_out[k])
		);
	end
endgenerate

endmodule

`default_nettype wire

// File: logic/pwm_channel.sv
`timescale 1ns/1ps
`default_nettype none
`include "periph_config.svh"

module pwm_channel (
	input  logic                 clk_sys,
	input  logic                 rst_n,

	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,

	output logic                 pwm_out
);

import periph_pkg::*;

offs_t offs;
logic  wr_en;

logic  csr_en; // CSR bit 0
duty_t div;
duty_t cmp;

duty_t div_ctr; // Prescaler, counts 0..DIV
duty_t ctr;     // Duty counter, wraps 255 -> 0

assign offs  = apb_req.paddr[`PERIPH_W_OFFS-1:0];
assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;

// ==================================================
//  Registers
// ==================================================

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		csr_en <= 1'b0;
		div    <= '0;
		cmp    <= '0;
	end else if (wr_en) begin
		case (offs)
			`PWM_REG_CSR: csr_en <= apb_req.pwdata[0];
			`PWM_REG_DIV: div    <= apb_req.pwdata[`PERIPH_W_DUTY-1:0];
			`PWM_REG_CMP: cmp    <= apb_req.pwdata[`PERIPH_W_DUTY-1:0];
			default: ;
		endcase
	end
end

always_comb begin
	apb_rsp.pready  = 1'b1; // No wait states
	apb_rsp.pslverr = 1'b0;
	case (offs)
		`PWM_REG_CSR: apb_rsp.prdata = word_t'(csr_en);
		`PWM_REG_DIV: apb_rsp.prdata = word_t'(div);
		`PWM_REG_CMP: apb_rsp.prdata = word_t'(cmp);
		default:      apb_rsp.prdata = '0;
	endcase
end

// ==================================================
//  Counter
// ==================================================

// Counter steps once every DIV+1 cycles while enabled
always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		div_ctr <= '0;
		ctr     <= '0;
	end else if (!csr_en) begin
		div_ctr <= '0;
		ctr     <= '0;
	end else if (div_ctr >= div) begin // Also catches DIV lowered mid-count
		div_ctr <= '0;
		ctr     <= ctr + 1'b1;
	end else begin
		div_ctr <= div_ctr + 1'b1;
	end
end

assign pwm_out = csr_en && (ctr < cmp);

// Splitter gates penable per slot, so it never rises on a deselected channel
assert property (@(posedge clk_sys) disable iff (!rst_n)
	$rose(apb_req.penable) |-> apb_req.psel)
	else $error("pwm_channel: penable rose without psel");

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
+incdir+bench
logic/periph_pkg.sv
logic/apb_splitter.sv
logic/pwm_channel.sv
logic/gpio_pads.sv
logic/periph_top.sv
bench/tb_periph.sv
